// File: src/lidar_params.svh
`ifndef LIDAR_PARAMS_SVH
`define LIDAR_PARAMS_SVH

// Clock cycles between shot attempts
`define SHOT_PERIOD 150

// Cycles allowed for the converter interrupt after a start pulse
`define INTB_TIMEOUT 100

// Clock cycles per half SPI clock period
`define SPI_CLK_DIV 2

// Clock cycles per UART bit
`define BAUD_DIV 8

// Sample FIFO holds 2**FIFO_DEPTH_LOG2 entries
`define FIFO_DEPTH_LOG2 2

// Converter result and shot tag widths
`define TOF_WIDTH 24
`define SHOT_ID_WIDTH 8

// Converter command byte, reads the TIME1 result register
`define TDC_READ_TIME1 8'h10

`endif

// File: src/lidar_pkg.sv
`include "lidar_params.svh"

package lidar_pkg;

  // One byte on the SPI bus or the serial line
  typedef logic [7:0] byte_t;

  // Field view of a sample, shot tag in the upper byte
  typedef struct packed {
    logic [`SHOT_ID_WIDTH-1:0] shot_id;
    logic [`TOF_WIDTH-1:0]     tof;
  } sample_fields_t;

  // Capture writes through fields
  // UART reads through bytes, index 3 is the shot tag
  typedef union packed {
    sample_fields_t fields;
    byte_t [3:0]    bytes;
  } sample_u;

endpackage

// File: src/spi_byte_if.sv
`timescale 1ns/1ns

interface spi_byte_if;
  import lidar_pkg::*;

  // Request from the capture stage
  logic  start;
  byte_t tx_byte;
  logic  cs_hold;

  // Status back from the SPI master
  logic  busy;
  // Valid once busy has dropped
  byte_t rx_byte;

  modport ctrl (
    output start, tx_byte, cs_hold,
    input  busy, rx_byte
  );

  modport master (
    input  start, tx_byte, cs_hold,
    output busy, rx_byte
  );

endinterface

// File: src/tdc_spi_master.sv
`timescale 1ns/1ns
`include "lidar_params.svh"

module tdc_spi_master (
  input  logic clk,
  input  logic reset,
  spi_byte_if.master bus,
  input  logic tdc_dout,
  output logic tdc_mosi,
  output logic tdc_sclk,
  output logic tdc_cs
);
  import lidar_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  byte_t            tx_shift;
  byte_t            rx_shift;
  logic             hold;

  // MSB always on the line, moves after each falling edge
  assign tdc_mosi    = tx_shift[7];
  assign bus.rx_byte = rx_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.busy <= 1'b0;
      tdc_sclk <= 1'b0;
      tdc_cs   <= 1'b1;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else if (!bus.busy) begin
      if (bus.start) begin
        // Chip select drops with the first bit already on mosi
        bus.busy <= 1'b1;
        tdc_cs   <= 1'b0;
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end
    end else if (div_cnt == DIV_W'(`SPI_CLK_DIV - 1)) begin
      div_cnt <= '0;
      if (!tdc_sclk) begin
        // Rising edge, converter data is sampled here
        tdc_sclk <= 1'b1;
      end else begin
        tdc_sclk <= 1'b0;
        bit_cnt  <= bit_cnt + 3'd1;
        // Last falling edge closes the byte
        if (bit_cnt == 3'd7) begin
          bus.busy <= 1'b0;
          tdc_cs   <= ~hold;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Shift registers and cs hold flag
  always_ff @(posedge clk) begin
    if (!bus.busy && bus.start) begin
      tx_shift <= bus.tx_byte;
      hold     <= bus.cs_hold;
    end else if (bus.busy && div_cnt == DIV_W'(`SPI_CLK_DIV - 1)) begin
      if (!tdc_sclk) begin
        rx_shift <= {rx_shift[6:0], tdc_dout};
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  // Capture side must wait for the previous byte to finish
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (reset) bus.start |-> !bus.busy
  );

endmodule

// File: src/tdc_capture.sv
`timescale 1ns/1ns
`include "lidar_params.svh"

module tdc_capture (
  input  logic clk,
  input  logic reset,
  input  logic tdc_intb,
  output logic tdc_start,
  spi_byte_if.ctrl spi,
  output lidar_pkg::sample_u sample,
  output logic sample_valid,
  input  logic sample_ready
);
  import lidar_pkg::*;

  localparam int TIMER_W = $clog2(`SHOT_PERIOD + 1);
  localparam int WAIT_W  = $clog2(`INTB_TIMEOUT + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_INT,
    ST_SPI_START,
    ST_SPI_WAIT,
    ST_HOLD
  } state_t;

  state_t                    state;
  logic [TIMER_W-1:0]        shot_timer;
  logic [WAIT_W-1:0]         wait_cnt;
  logic [1:0]                byte_idx;
  logic [`SHOT_ID_WIDTH-1:0] shot_cnt;
  logic                      shot_due;
  logic                      fire;

  // Timer saturates and waits for the idle state
  assign shot_due = (shot_timer == TIMER_W'(`SHOT_PERIOD - 1));
  assign fire     = (state == ST_IDLE) && shot_due;

  // Byte 0 is the read command, then three dummy bytes clock the result out
  assign spi.start   = (state == ST_SPI_START);
  assign spi.tx_byte = (byte_idx == 2'd0) ? byte_t'(`TDC_READ_TIME1) : byte_t'(0);
  assign spi.cs_hold = (byte_idx != 2'd3);

  assign sample_valid = (state == ST_HOLD);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      shot_timer <= '0;
      wait_cnt   <= '0;
      byte_idx   <= '0;
      shot_cnt   <= '0;
      tdc_start  <= 1'b0;
    end else begin
      tdc_start <= fire;
      // Shot timer
      if (fire) begin
        shot_timer <= '0;
      end else if (!shot_due) begin
        shot_timer <= shot_timer + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (fire) begin
            shot_cnt <= shot_cnt + 1'b1;
            wait_cnt <= '0;
            state    <= ST_WAIT_INT;
          end
        end
        ST_WAIT_INT: begin
          // Interrupt is active low
          if (!tdc_intb) begin
            byte_idx <= '0;
            state    <= ST_SPI_START;
          end else if (wait_cnt == WAIT_W'(`INTB_TIMEOUT - 1)) begin
            // No echo, drop this shot
            state <= ST_IDLE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ST_SPI_START: begin
          state <= ST_SPI_WAIT;
        end
        ST_SPI_WAIT: begin
          if (!spi.busy) begin
            if (byte_idx == 2'd3) begin
              state <= ST_HOLD;
            end else begin
              byte_idx <= byte_idx + 2'd1;
              state    <= ST_SPI_START;
            end
          end
        end
        ST_HOLD: begin
          // Held until the FIFO takes it
          if (sample_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Sample assembly through the field view
  always_ff @(posedge clk) begin
    if (fire) begin
      sample.fields.shot_id <= shot_cnt;
    end
    // Read bytes arrive MSB first
    if (state == ST_SPI_WAIT && !spi.busy && byte_idx != 2'd0) begin
      sample.fields.tof <= {sample.fields.tof[`TOF_WIDTH-9:0], spi.rx_byte};
    end
  end

  a_sample_stable: assert property (
    @(posedge clk) disable iff (reset)
    sample_valid && !sample_ready |=> sample_valid && $stable(sample)
  );

endmodule

// File: src/sample_fifo.sv
`timescale 1ns/1ns
`include "lidar_params.svh"

module sample_fifo (
  input  logic clk,
  input  logic reset,
  input  lidar_pkg::sample_u in_data,
  input  logic in_valid,
  output logic in_ready,
  output lidar_pkg::sample_u out_data,
  output logic out_valid,
  input  logic out_ready
);
  import lidar_pkg::*;

  localparam int PTR_W = `FIFO_DEPTH_LOG2;
  localparam int CNT_W = `FIFO_DEPTH_LOG2 + 1;
  localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;

  sample_u          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Flags straight from the fill level
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally at the power-of-two depth
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // A write never lands on the oldest unread entry
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (reset)
    push |-> (wr_ptr != rd_ptr) || (count == '0)
  );

endmodule

// File: src/uart_packer.sv
`timescale 1ns/1ns
`include "lidar_params.svh"

module uart_packer (
  input  logic clk,
  input  logic reset,
  input  lidar_pkg::sample_u sample,
  input  logic sample_valid,
  output logic sample_ready,
  output logic serial_out
);
  import lidar_pkg::*;

  localparam int BAUD_W = $clog2(`BAUD_DIV + 1);

  logic              frame_active;
  sample_u           data;
  logic [1:0]        byte_idx;
  logic [3:0]        bit_cnt;
  logic [BAUD_W-1:0] baud_cnt;
  // Stop bit above the data byte, LSB goes out first
  logic [8:0]        shifter;
  logic              baud_tick;

  assign sample_ready = !frame_active;
  assign baud_tick    = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_active <= 1'b0;
      serial_out   <= 1'b1;
      byte_idx     <= '0;
      bit_cnt      <= '0;
      baud_cnt     <= '0;
    end else if (!frame_active) begin
      if (sample_valid) begin
        // Start bit of the shot tag byte
        frame_active <= 1'b1;
        serial_out   <= 1'b0;
        byte_idx     <= 2'd3;
        bit_cnt      <= '0;
        baud_cnt     <= '0;
      end
    end else if (baud_tick) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit done
        if (byte_idx == 2'd0) begin
          frame_active <= 1'b0;
        end else begin
          byte_idx   <= byte_idx - 2'd1;
          serial_out <= 1'b0;
          bit_cnt    <= '0;
        end
      end else begin
        serial_out <= shifter[0];
        bit_cnt    <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Payload side, byte view of the latched sample
  always_ff @(posedge clk) begin
    if (!frame_active && sample_valid) begin
      data    <= sample;
      shifter <= {1'b1, sample.bytes[3]};
    end else if (frame_active && baud_tick) begin
      if (bit_cnt == 4'd9) begin
        shifter <= {1'b1, data.bytes[byte_idx - 2'd1]};
      end else begin
        shifter <= {1'b1, shifter[8:1]};
      end
    end
  end

  // Line idles high between samples
  a_idle_high: assert property (
    @(posedge clk) disable iff (reset) !frame_active |-> serial_out
  );

endmodule

// File: src/lidar_top.sv
`timescale 1ns/1ns

module lidar_top (
  input  logic clk,
  input  logic reset,
  input  logic tdc_intb,
  input  logic tdc_dout,
  output logic tdc_start,
  output logic tdc_cs,
  output logic tdc_sclk,
  output logic tdc_mosi,
  output logic serial_out
);
  import lidar_pkg::*;

  // Capture to FIFO
  sample_u cap_sample;
  logic    cap_valid;
  logic    cap_ready;
  // FIFO to UART
  sample_u fifo_sample;
  logic    fifo_valid;
  logic    fifo_ready;

  spi_byte_if spi_bus ();

  tdc_capture tdc_capture_inst (
    .clk          (clk),
    .reset        (reset),
    .tdc_intb     (tdc_intb),
    .tdc_start    (tdc_start),
    .spi          (spi_bus.ctrl),
    .sample       (cap_sample),
    .sample_valid (cap_valid),
    .sample_ready (cap_ready)
  );

  tdc_spi_master tdc_spi_master_inst (
    .clk      (clk),
    .reset    (reset),
    .bus      (spi_bus.master),
    .tdc_dout (tdc_dout),
    .tdc_mosi (tdc_mosi),
    .tdc_sclk (tdc_sclk),
    .tdc_cs   (tdc_cs)
  );

  sample_fifo sample_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (cap_sample),
    .in_valid  (cap_valid),
    .in_ready  (cap_ready),
    .out_data  (fifo_sample),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  uart_packer uart_packer_inst (
    .clk          (clk),
    .reset        (reset),
    .sample       (fifo_sample),
    .sample_valid (fifo_valid),
    .sample_ready (fifo_ready),
    .serial_out   (serial_out)
  );

endmodule

// File: test/lidar_tb.sv
`timescale 1ns/1ns
`include "lidar_params.svh"

module lidar_tb;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_SHOTS  = 40;
  // Shot time with slack plus four 10-bit frames per sample
  localparam int WATCHDOG_CYCLES = 60 * `SHOT_PERIOD + NUM_SHOTS * 4 * 10 * `BAUD_DIV;

  logic clk;
  logic reset;
  logic tdc_intb;
  logic tdc_dout;
  logic tdc_start;
  logic tdc_cs;
  logic tdc_sclk;
  logic tdc_mosi;
  logic serial_out;

  // Converter model to UART checker, {shot, tof} per answered shot
  logic [31:0] expected_q[$];
  logic [31:0] answer_word;
  int          groups_done;

  // Chip select window monitor
  logic        mon_cs_prev;
  logic        mon_sclk_prev;
  int          win_edges;
  logic [7:0]  cmd_bits;

  // Shot spacing monitor
  int          cycle_cnt;
  int          last_start;
  logic        first_shot_seen;

  lidar_top lidar_top_inst (
    .clk        (clk),
    .reset      (reset),
    .tdc_intb   (tdc_intb),
    .tdc_dout   (tdc_dout),
    .tdc_start  (tdc_start),
    .tdc_cs     (tdc_cs),
    .tdc_sclk   (tdc_sclk),
    .tdc_mosi   (tdc_mosi),
    .serial_out (serial_out)
  );

  task automatic halt_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : main_sequence
    int good_shots;
    int s;
    // Every fifth shot is left unanswered by the converter model
    good_shots = 0;
    for (s = 0; s < NUM_SHOTS; s++) begin
      if (s % 5 != 0) begin
        good_shots++;
      end
    end
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (groups_done < good_shots) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    halt_run("Timeout, not all sample groups arrived on the serial line");
  end

  // Converter model, interrupt side
  initial begin : converter_model
    int          shot_num;
    int          delay;
    logic [23:0] value;
    void'($urandom(32'hcab9));
    tdc_intb    = 1'b1;
    shot_num    = 0;
    answer_word = '0;
    forever begin
      @(posedge clk);
      if (!reset && tdc_start) begin
        delay       = 1 + int'($urandom % 60);
        value       = 24'($urandom);
        // Command byte slot reads back zero
        answer_word = {8'h00, value};
        if (shot_num % 5 != 0) begin
          repeat (delay) @(posedge clk);
          tdc_intb <= 1'b0;
          expected_q.push_back({shot_num[7:0], value});
          // Interrupt cleared once the readout starts
          do @(posedge clk); while (tdc_cs);
          tdc_intb <= 1'b1;
        end
        shot_num = shot_num + 1;
      end
    end
  end

  // Converter model, SPI data out, mode 0
  initial begin : converter_dout
    logic cs_last;
    logic sclk_last;
    int   idx;
    tdc_dout  = 1'b0;
    cs_last   = 1'b1;
    sclk_last = 1'b0;
    idx       = -1;
    forever begin
      @(posedge clk);
      if (!tdc_cs && cs_last) begin
        // First bit ready before the first rising sclk
        tdc_dout <= answer_word[31];
        idx = 30;
      end else if (!tdc_cs && sclk_last && !tdc_sclk && idx >= 0) begin
        // Next bit after each falling edge
        tdc_dout <= answer_word[idx];
        idx = idx - 1;
      end
      cs_last   = tdc_cs;
      sclk_last = tdc_sclk;
    end
  end

  // UART receiver, one 8N1 frame sampled mid-bit
  task automatic receive_byte(output logic [7:0] data);
    int i;
    do @(posedge clk); while (serial_out);
    repeat (`BAUD_DIV / 2 - 1) @(posedge clk);
    assert (serial_out == 1'b0) else halt_run("Start bit did not stay low until mid-bit");
    for (i = 0; i < 8; i++) begin
      repeat (`BAUD_DIV) @(posedge clk);
      data[i] = serial_out;
    end
    repeat (`BAUD_DIV) @(posedge clk);
    assert (serial_out) else halt_run("Stop bit was low");
  endtask

  task automatic check_group(input logic [31:0] group);
    logic [31:0] expected;
    assert (expected_q.size() != 0)
      else halt_run("Sample group arrived with no answered shot left to match");
    expected = expected_q.pop_front();
    // Shot tag first, then tof high to low
    assert (group[31:24] == expected[31:24])
      else halt_run($sformatf("Fail serial shot_id = %h, expected %h",
                              group[31:24], expected[31:24]));
    assert (group[23:0] == expected[23:0])
      else halt_run($sformatf("Fail serial tof = %h, expected %h",
                              group[23:0], expected[23:0]));
  endtask

  initial begin : uart_receiver
    logic [7:0]  rx;
    logic [31:0] group;
    int          k;
    groups_done  = 0;
    group        = '0;
    do @(posedge clk); while (reset);
    forever begin
      for (k = 0; k < 4; k++) begin
        receive_byte(rx);
        group = {group[23:0], rx};
      end
      check_group(group);
      groups_done++;
    end
  end

  // Chip select window, edge count and command byte
  always @(posedge clk) begin
    if (reset) begin
      mon_cs_prev   <= 1'b1;
      mon_sclk_prev <= 1'b0;
      win_edges     <= 0;
      cmd_bits      <= '0;
    end else begin
      mon_cs_prev   <= tdc_cs;
      mon_sclk_prev <= tdc_sclk;
      if (!tdc_cs && tdc_sclk && !mon_sclk_prev) begin
        win_edges <= win_edges + 1;
        if (win_edges < 8) begin
          cmd_bits <= {cmd_bits[6:0], tdc_mosi};
        end
      end
      if (tdc_cs && !mon_cs_prev) begin
        assert (win_edges == 32)
          else halt_run($sformatf("Fail sclk rising edges in window = %h, expected %h",
                                  win_edges, 32));
        assert (cmd_bits == `TDC_READ_TIME1)
          else halt_run($sformatf("Fail first tdc_mosi byte = %h, expected %h",
                                  cmd_bits, `TDC_READ_TIME1));
        win_edges <= 0;
      end
    end
  end

  // Shot spacing
  always @(posedge clk) begin
    if (reset) begin
      cycle_cnt       <= 0;
      last_start      <= 0;
      first_shot_seen <= 1'b0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (tdc_start) begin
        if (first_shot_seen) begin
          assert (cycle_cnt - last_start >= `SHOT_PERIOD)
            else halt_run($sformatf("Fail tdc_start spacing = %h cycles, minimum %h",
                                    cycle_cnt - last_start, `SHOT_PERIOD));
        end
        last_start      <= cycle_cnt;
        first_shot_seen <= 1'b1;
      end
    end
  end

  // Quiet outputs until the first shot
  a_idle_before_first_shot: assert property (
    @(posedge clk) disable iff (reset)
    !first_shot_seen |-> tdc_cs && !tdc_sclk && serial_out
  ) else halt_run($sformatf("Fail before first shot tdc_cs = %h tdc_sclk = %h serial_out = %h",
                            $sampled(tdc_cs), $sampled(tdc_sclk), $sampled(serial_out)));

  a_start_one_cycle: assert property (
    @(posedge clk) disable iff (reset) tdc_start |=> !tdc_start
  ) else halt_run($sformatf("Fail tdc_start = %h on the cycle after a pulse",
                            $sampled(tdc_start)));

endmodule

// File: flist.f
+incdir+src
src/lidar_pkg.sv
src/spi_byte_if.sv
src/tdc_spi_master.sv
src/tdc_capture.sv
src/sample_fifo.sv
src/uart_packer.sv
src/lidar_top.sv
test/lidar_tb.sv

// File: Makefile
TOP = lidar_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard src/*.sv src/*.svh test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
